// ==== verilog/portal_params.svh ====
`ifndef PORTAL_PARAMS_SVH
`define PORTAL_PARAMS_SVH

// Bus and payload widths
`define PORTAL_ADDR_W 16
`define PORTAL_DATA_W 32
`define PORTAL_ID_W 6
`define PORTAL_LEN_W 4  // Holds beats minus one

// Address map fields
`define PORTAL_OFS_LSB 2  // Word offset sits in bits 4..2
`define PORTAL_WIN_BIT 11  // 0 selects control, 1 selects FIFO
`define PORTAL_SEL_BIT 12  // 0 selects indication, 1 selects request

// Echo queue behind the portals
`define ECHO_DEPTH 4

// Portal identity words
`define IND_PORTAL_NUM 5
`define REQ_PORTAL_NUM 6
`define PORTAL_COUNT 2

`endif

// ==== verilog/portalPkg.sv ====
`default_nettype none

`include "portal_params.svh"

package portalPkg;

  // Burst request from the bus master, for reads and writes alike
  typedef struct packed {
    logic [`PORTAL_ADDR_W-1:0] addr;
    logic [`PORTAL_LEN_W-1:0]  len;
    logic [`PORTAL_ID_W-1:0]   id;
  } burstReqT;

  // One word access to a portal register
  typedef struct packed {
    logic                    portal;   // High for the request portal
    logic                    fifoWin;  // High for the FIFO window
    logic [2:0]              offset;
    logic [`PORTAL_ID_W-1:0] id;
    logic                    last;
  } portalBeatT;

  typedef struct packed {
    logic [`PORTAL_DATA_W-1:0] data;
    logic                      last;
  } writeBeatT;

  typedef struct packed {
    logic [`PORTAL_DATA_W-1:0] data;
    logic [`PORTAL_ID_W-1:0]   id;
    logic                      last;
  } readBeatT;

  typedef struct packed {
    logic [`PORTAL_ID_W-1:0] id;
  } doneT;

endpackage

`default_nettype wire

// ==== verilog/portalFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalFifo #(
  parameter int  DEPTH = 2,
  parameter type T     = logic
) (
  input  logic CLK,
  input  logic RST_N,
  input  logic inValid,
  input  T     inData,
  output logic inReady,
  output logic outValid,
  output T     outData,
  input  logic outReady
);

  localparam int               PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign outValid = (count != '0);
  assign inReady  = (count != FULL_CNT) || outReady;  // A full queue still takes a push beside a pop
  assign push     = inValid && inReady;
  assign pop      = outValid && outReady;
  assign outData  = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push)
        wrPtr <= (wrPtr == LAST_IDX) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == LAST_IDX) ? '0 : rdPtr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push)
      mem[wrPtr] <= inData;
  end

endmodule

`default_nettype wire

// ==== verilog/burstSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module burstSequencer
  import portalPkg::*;
(
  input  logic       CLK,
  input  logic       RST_N,
  input  logic       reqValid,
  input  burstReqT   req,
  output logic       reqReady,
  output logic       beatValid,
  output portalBeatT beat,
  input  logic       beatReady
);

  logic                     busy;
  logic [2:0]               offset;
  logic [`PORTAL_LEN_W-1:0] remaining;  // Beats still to go after the present one
  logic [`PORTAL_ID_W-1:0]  id;
  logic                     portalSel;
  logic                     fifoWin;
  logic                     reqFire;
  logic                     beatFire;

  assign reqReady  = !busy;
  assign beatValid = busy;
  assign reqFire   = reqValid && reqReady;
  assign beatFire  = beatValid && beatReady;

  always_comb begin
    beat.portal  = portalSel;
    beat.fifoWin = fifoWin;
    beat.offset  = offset;
    beat.id      = id;
    beat.last    = (remaining == '0);
  end

  always_ff @(posedge CLK) begin
    if (!RST_N)
      busy <= 1'b0;
    else if (reqFire)
      busy <= 1'b1;
    else if (beatFire && beat.last)
      busy <= 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (reqFire) begin
      offset    <= req.addr[`PORTAL_OFS_LSB +: 3];
      remaining <= req.len;
      id        <= req.id;
      portalSel <= req.addr[`PORTAL_SEL_BIT];
      fifoWin   <= req.addr[`PORTAL_WIN_BIT];
    end else if (beatFire) begin
      offset    <= offset + 3'd1;  // Wraps inside the 32-byte window
      remaining <= remaining - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/portalRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module portalRegs
  import portalPkg::*;
(
  input  logic                      CLK,
  input  logic                      RST_N,
  input  portalBeatT                rdBeat,
  input  logic                      rdStrobe,
  output logic [`PORTAL_DATA_W-1:0] rdData,
  input  portalBeatT                wrBeat,
  input  logic [`PORTAL_DATA_W-1:0] wrData,
  input  logic                      wrStrobe,
  output logic                      wrBusy,
  output logic                      irq
);

  localparam int DW = `PORTAL_DATA_W;

  logic          indEnable;
  logic          reqEnable;
  logic          pushBeat;
  logic          popBeat;
  logic          echoReady;
  logic          echoValid;
  logic [DW-1:0] echoHead;
  logic          rdPending;
  logic          rdEnable;

  assign pushBeat  = wrBeat.portal && wrBeat.fifoWin && (wrBeat.offset == 3'd0);
  assign popBeat   = !rdBeat.portal && rdBeat.fifoWin && (rdBeat.offset == 3'd0);
  assign wrBusy    = pushBeat && !echoReady;  // Holds the write path until a pop frees a slot
  assign irq       = indEnable && echoValid;
  assign rdPending = !rdBeat.portal && echoValid;  // Request portal never has anything pending
  assign rdEnable  = rdBeat.portal ? reqEnable : indEnable;

  // Echo queue standing in for the user logic
  portalFifo #(
    .DEPTH(`ECHO_DEPTH),
    .T    (logic [DW-1:0])
  ) echoQ (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .inValid (wrStrobe && pushBeat),
    .inData  (wrData),
    .inReady (echoReady),
    .outValid(echoValid),
    .outData (echoHead),
    .outReady(rdStrobe && popBeat)
  );

  always_comb begin
    rdData = '0;
    if (!rdBeat.fifoWin) begin
      case (rdBeat.offset)
        3'd0, 3'd3: rdData = DW'(rdPending);
        3'd1:       rdData = DW'(rdEnable);
        3'd2:       rdData = DW'(1);  // One channel per portal
        3'd4:       rdData = rdBeat.portal ? DW'(`REQ_PORTAL_NUM) : DW'(`IND_PORTAL_NUM);
        3'd5:       rdData = DW'(`PORTAL_COUNT);
        default:    rdData = '0;
      endcase
    end else if (rdBeat.portal) begin
      if (rdBeat.offset == 3'd1)
        rdData = DW'(echoReady);
    end else begin
      case (rdBeat.offset)
        3'd0:    rdData = echoValid ? echoHead : '0;
        3'd1:    rdData = DW'(echoValid);
        default: rdData = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indEnable <= 1'b0;
      reqEnable <= 1'b0;
    end else if (wrStrobe && !wrBeat.fifoWin && (wrBeat.offset == 3'd1)) begin
      if (wrBeat.portal)
        reqEnable <= wrData[0];
      else
        indEnable <= wrData[0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/portalReadPath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module portalReadPath
  import portalPkg::*;
(
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic                      beatValid,
  input  portalBeatT                beat,
  output logic                      beatReady,
  output portalBeatT                rdBeat,
  output logic                      rdStrobe,
  input  logic [`PORTAL_DATA_W-1:0] rdData,
  output logic                      outValid,
  output readBeatT                  out,
  input  logic                      outReady
);

  readBeatT result;
  logic     resultReady;

  assign rdBeat    = beat;
  assign rdStrobe  = beatValid && resultReady;  // A pop only happens once the data has a slot
  assign beatReady = resultReady;

  always_comb begin
    result.data = rdData;
    result.id   = beat.id;
    result.last = beat.last;
  end

  portalFifo #(
    .DEPTH(2),
    .T    (readBeatT)
  ) resultQ (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .inValid (beatValid),
    .inData  (result),
    .inReady (resultReady),
    .outValid(outValid),
    .outData (out),
    .outReady(outReady)
  );

endmodule

`default_nettype wire

// ==== verilog/portalWritePath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module portalWritePath
  import portalPkg::*;
(
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic                      beatValid,
  input  portalBeatT                beat,
  output logic                      beatReady,
  input  logic                      dataValid,
  input  writeBeatT                 data,
  output logic                      dataReady,
  output portalBeatT                wrBeat,
  output logic [`PORTAL_DATA_W-1:0] wrData,
  output logic                      wrStrobe,
  input  logic                      wrBusy,
  output logic                      doneValid,
  output doneT                      done,
  input  logic                      doneReady
);

  doneT doneIn;
  logic doneRoom;
  logic fire;

  // The sequencer decides the burst end, so data.last plays no part here
  assign fire      = beatValid && dataValid && !wrBusy && (!beat.last || doneRoom);
  assign beatReady = fire;
  assign dataReady = fire;
  assign wrBeat    = beat;
  assign wrData    = data.data;
  assign wrStrobe  = fire;
  assign doneIn.id = beat.id;

  portalFifo #(
    .DEPTH(2),
    .T    (doneT)
  ) doneQ (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .inValid (fire && beat.last),
    .inData  (doneIn),
    .inReady (doneRoom),
    .outValid(doneValid),
    .outData (done),
    .outReady(doneReady)
  );

endmodule

`default_nettype wire

// ==== verilog/portalBridgeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module portalBridgeTop
  import portalPkg::*;
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     rdReqValid,
  input  burstReqT rdReq,
  output logic     rdReqReady,
  output logic     rdValid,
  output readBeatT rdBeat,
  input  logic     rdReady,
  input  logic     wrReqValid,
  input  burstReqT wrReq,
  output logic     wrReqReady,
  input  logic     wrDataValid,
  input  writeBeatT wrData,
  output logic     wrDataReady,
  output logic     doneValid,
  output doneT     done,
  input  logic     doneReady,
  output logic     irq
);

  portalBeatT                rdSeqBeat;
  logic                      rdSeqValid;
  logic                      rdSeqReady;
  portalBeatT                rdPathBeat;
  logic                      rdPathValid;
  logic                      rdPathReady;
  portalBeatT                wrSeqBeat;
  logic                      wrSeqValid;
  logic                      wrSeqReady;
  portalBeatT                wrPathBeat;
  logic                      wrPathValid;
  logic                      wrPathReady;
  writeBeatT                 wrDataQ;
  logic                      wrDataQValid;
  logic                      wrDataQReady;
  portalBeatT                regRdBeat;
  logic                      regRdStrobe;
  logic [`PORTAL_DATA_W-1:0] regRdData;
  portalBeatT                regWrBeat;
  logic [`PORTAL_DATA_W-1:0] regWrData;
  logic                      regWrStrobe;
  logic                      regWrBusy;

  // Read pipeline
  burstSequencer rdSeq (
    .CLK(CLK), .RST_N(RST_N), .reqValid(rdReqValid), .req(rdReq), .reqReady(rdReqReady),
    .beatValid(rdSeqValid), .beat(rdSeqBeat), .beatReady(rdSeqReady)
  );

  portalFifo #(.DEPTH(2), .T(portalBeatT)) rdBeatQ (
    .CLK(CLK), .RST_N(RST_N), .inValid(rdSeqValid), .inData(rdSeqBeat), .inReady(rdSeqReady),
    .outValid(rdPathValid), .outData(rdPathBeat), .outReady(rdPathReady)
  );

  portalReadPath readPath (
    .CLK(CLK), .RST_N(RST_N), .beatValid(rdPathValid), .beat(rdPathBeat),
    .beatReady(rdPathReady), .rdBeat(regRdBeat), .rdStrobe(regRdStrobe), .rdData(regRdData),
    .outValid(rdValid), .out(rdBeat), .outReady(rdReady)
  );

  // Write pipeline
  burstSequencer wrSeq (
    .CLK(CLK), .RST_N(RST_N), .reqValid(wrReqValid), .req(wrReq), .reqReady(wrReqReady),
    .beatValid(wrSeqValid), .beat(wrSeqBeat), .beatReady(wrSeqReady)
  );

  portalFifo #(.DEPTH(2), .T(portalBeatT)) wrBeatQ (
    .CLK(CLK), .RST_N(RST_N), .inValid(wrSeqValid), .inData(wrSeqBeat), .inReady(wrSeqReady),
    .outValid(wrPathValid), .outData(wrPathBeat), .outReady(wrPathReady)
  );

  portalFifo #(.DEPTH(2), .T(writeBeatT)) wrDataQueue (
    .CLK(CLK), .RST_N(RST_N), .inValid(wrDataValid), .inData(wrData), .inReady(wrDataReady),
    .outValid(wrDataQValid), .outData(wrDataQ), .outReady(wrDataQReady)
  );

  portalWritePath writePath (
    .CLK(CLK), .RST_N(RST_N), .beatValid(wrPathValid), .beat(wrPathBeat),
    .beatReady(wrPathReady), .dataValid(wrDataQValid), .data(wrDataQ),
    .dataReady(wrDataQReady), .wrBeat(regWrBeat), .wrData(regWrData),
    .wrStrobe(regWrStrobe), .wrBusy(regWrBusy), .doneValid(doneValid), .done(done),
    .doneReady(doneReady)
  );

  portalRegs regs (
    .CLK(CLK), .RST_N(RST_N), .rdBeat(regRdBeat), .rdStrobe(regRdStrobe), .rdData(regRdData),
    .wrBeat(regWrBeat), .wrData(regWrData), .wrStrobe(regWrStrobe), .wrBusy(regWrBusy),
    .irq(irq)
  );

endmodule

`default_nettype wire

// ==== test/portalBridgeProps.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalBridgeProps
  import portalPkg::*;
(
  input logic       CLK,
  input logic       RST_N,
  input logic       rdValid,
  input readBeatT   rdBeat,
  input logic       rdReady,
  input logic       doneValid,
  input doneT       done,
  input logic       doneReady,
  input logic       irq,
  input logic       wrStrobe,
  input portalBeatT wrBeat,
  input logic       wrBit
);

  logic indEnShadow;

  // Follows the indication enable from the control writes that reach the registers
  always_ff @(posedge CLK) begin
    if (!RST_N)
      indEnShadow <= 1'b0;
    else if (wrStrobe && !wrBeat.portal && !wrBeat.fifoWin && (wrBeat.offset == 3'd1))
      indEnShadow <= wrBit;
  end

  rdHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    rdValid && !rdReady |=> rdValid && $stable(rdBeat))
    else $error("rdBeat changed or dropped while rdReady was low");

  doneHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    doneValid && !doneReady |=> doneValid && $stable(done))
    else $error("done changed or dropped while doneReady was low");

  irqNeedsEnable: assert property (@(posedge CLK) disable iff (!RST_N) irq |-> indEnShadow)
    else $error("irq is high while the indication enable is clear");

  // Outputs stay quiet through reset
  resetQuiet: assert property (@(posedge CLK) !RST_N |=> !rdValid && !doneValid)
    else $error("a valid output is high during reset");

endmodule

bind portalBridgeTop portalBridgeProps props (
  .CLK(CLK), .RST_N(RST_N), .rdValid(rdValid), .rdBeat(rdBeat), .rdReady(rdReady),
  .doneValid(doneValid), .done(done), .doneReady(doneReady), .irq(irq),
  .wrStrobe(regWrStrobe), .wrBeat(regWrBeat), .wrBit(regWrData[0])
);

`default_nettype wire

// ==== test/portalBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "portal_params.svh"

module portalBridgeTb
  import portalPkg::*;
();

  localparam int AW          = `PORTAL_ADDR_W;
  localparam int DW          = `PORTAL_DATA_W;
  localparam int IW          = `PORTAL_ID_W;
  localparam int LW          = `PORTAL_LEN_W;
  localparam int NUM_TESTS   = 200;
  localparam int CYCLE_LIMIT = NUM_TESTS * (1 << LW) * 12 + 100;  // Worst burst with slow readies

  logic      CLK;
  logic      RST_N;
  logic      rdReqValid;
  burstReqT  rdReq;
  logic      rdReqReady;
  logic      rdValid;
  readBeatT  rdBeat;
  logic      rdReady;
  logic      wrReqValid;
  burstReqT  wrReq;
  logic      wrReqReady;
  logic      wrDataValid;
  writeBeatT wrData;
  logic      wrDataReady;
  logic      doneValid;
  doneT      done;
  logic      doneReady;
  logic      irq;

  logic [DW-1:0] echoModel[$];
  logic          indEnModel;
  logic          reqEnModel;
  int            errors;
  int            checks;
  int            cycles;

  portalBridgeTop DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkRead(input readBeatT got, input readBeatT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: rdBeat got data %h id %0d last %b, expected data %h id %0d last %b",
               $time, got.data, got.id, got.last, exp.data, exp.id, exp.last);
    end
  endtask

  task automatic checkDone(input doneT got, input doneT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: done.id got %0d expected %0d", $time, got.id, exp.id);
    end
  endtask

  task automatic checkIrq(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: irq got %b expected %b", $time, got, exp);
    end
  endtask

  // Register map of the portals, with the echo queue behind them
  function automatic logic [DW-1:0] modelRead(input logic portal, input logic win,
                                              input logic [2:0] off);
    logic [DW-1:0] val;
    val = '0;
    if (!win) begin
      case (off)
        3'd0, 3'd3: val = DW'(!portal && echoModel.size() != 0);
        3'd1:       val = DW'(portal ? reqEnModel : indEnModel);
        3'd2:       val = DW'(1);
        3'd4:       val = portal ? DW'(`REQ_PORTAL_NUM) : DW'(`IND_PORTAL_NUM);
        3'd5:       val = DW'(`PORTAL_COUNT);
        default:    val = '0;
      endcase
    end else if (portal && off == 3'd1) begin
      val = DW'(echoModel.size() < `ECHO_DEPTH);
    end else if (!portal && off == 3'd0 && echoModel.size() != 0) begin
      val = echoModel.pop_front();
    end else if (!portal && off == 3'd1) begin
      val = DW'(echoModel.size() != 0);
    end
    return val;
  endfunction

  function automatic void modelWrite(input logic portal, input logic win, input logic [2:0] off,
                                     input logic [DW-1:0] data);
    if (!win && off == 3'd1 && portal)
      reqEnModel = data[0];
    else if (!win && off == 3'd1)
      indEnModel = data[0];
    if (portal && win && off == 3'd0)
      echoModel.push_back(data);
  endfunction

  task automatic runRead(input burstReqT r);
    readBeatT   exp;
    logic [2:0] off;
    int         beat;
    off        = r.addr[`PORTAL_OFS_LSB +: 3];
    rdReqValid = 1'b1;
    rdReq      = r;
    while (!rdReqReady) @(negedge CLK);
    @(negedge CLK);
    rdReqValid = 1'b0;
    beat       = 0;
    while (beat <= int'(r.len)) begin
      rdReady = ($urandom % 4) != 0;
      if (rdValid && rdReady) begin  // Transfer happens on the coming rising edge
        exp.data = modelRead(r.addr[`PORTAL_SEL_BIT], r.addr[`PORTAL_WIN_BIT], off);
        exp.id   = r.id;
        exp.last = (beat == int'(r.len));
        checkRead(rdBeat, exp);
        off = off + 3'd1;
        beat++;
      end
      @(negedge CLK);
    end
    rdReady = 1'b0;
  endtask

  task automatic runWrite(input burstReqT r);
    doneT       exp;
    logic [2:0] off;
    int         pushes;
    logic       gotDone;
    off    = r.addr[`PORTAL_OFS_LSB +: 3];
    pushes = 0;
    for (int i = 0; i <= int'(r.len); i++)
      if (3'(off + 3'(i)) == 3'd0)
        pushes++;
    // A push into a full echo queue would wait for a read that never comes
    if (r.addr[`PORTAL_SEL_BIT] && r.addr[`PORTAL_WIN_BIT] &&
        echoModel.size() + pushes > `ECHO_DEPTH)
      r.addr[`PORTAL_WIN_BIT] = 1'b0;
    wrReqValid = 1'b1;
    wrReq      = r;
    while (!wrReqReady) @(negedge CLK);
    @(negedge CLK);
    wrReqValid = 1'b0;
    for (int i = 0; i <= int'(r.len); i++) begin
      wrDataValid  = 1'b1;
      wrData.data  = $urandom;
      wrData.last  = (i == int'(r.len));
      while (!wrDataReady) @(negedge CLK);
      modelWrite(r.addr[`PORTAL_SEL_BIT], r.addr[`PORTAL_WIN_BIT], off, wrData.data);
      off = off + 3'd1;
      @(negedge CLK);
    end
    wrDataValid = 1'b0;
    exp.id      = r.id;
    gotDone     = 1'b0;
    while (!gotDone) begin
      doneReady = ($urandom % 4) != 0;
      if (doneValid && doneReady) begin
        checkDone(done, exp);
        gotDone = 1'b1;
      end
      @(negedge CLK);
    end
    doneReady = 1'b0;
  endtask

  // No beat or done id may follow the end of a burst
  task automatic checkQuiet();
    repeat (3) begin
      if (rdValid || doneValid) begin
        errors++;
        $display("unexpected extra response at %0t after the burst ended", $time);
      end
      @(negedge CLK);
    end
    checkIrq(irq, indEnModel && echoModel.size() != 0);
  endtask

  initial begin
    burstReqT r;
    int       errBefore;
    string    kind;
    string    verdict;
    void'($urandom(32'h1df9_905f));
    RST_N       = 1'b0;
    rdReqValid  = 1'b0;
    rdReq       = '0;
    rdReady     = 1'b0;
    wrReqValid  = 1'b0;
    wrReq       = '0;
    wrDataValid = 1'b0;
    wrData      = '0;
    doneReady   = 1'b0;
    indEnModel  = 1'b0;
    reqEnModel  = 1'b0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    checkIrq(irq, 1'b0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      r.addr    = AW'($urandom);
      r.len     = LW'($urandom);
      r.id      = IW'($urandom);
      errBefore = errors;
      if ($urandom % 2) begin
        kind = "write";
        runWrite(r);
      end else begin
        kind = "read";
        runRead(r);
      end
      checkQuiet();
      if (errors == errBefore)
        verdict = "ok";
      else
        verdict = "errors";
      $display("test %0d %s addr %h len %0d id %0d: %s", t, kind, r.addr, r.len, r.id, verdict);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/portalPkg.sv
verilog/portalFifo.sv
verilog/burstSequencer.sv
verilog/portalRegs.sv
verilog/portalReadPath.sv
verilog/portalWritePath.sv
verilog/portalBridgeTop.sv
test/portalBridgeProps.sv
test/portalBridgeTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module portalBridgeTb
	@out="$$(./obj_dir/VportalBridgeTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
